/* FpIssueSubsystem.f */
+incdir+testbench
hdl/FpOpTypes.sv
hdl/ActiveListTypes.sv
hdl/FpIssueQueue.sv
hdl/FpIssueStage.sv
hdl/FpDivSqrtUnit.sv
hdl/FpRegisterReadStage.sv
hdl/FpIssueSubsystem.sv
testbench/FpIssueTb.sv

/* testbench/FpIssueTests.svh */
////////////////////////////////////////
// Directed tests and the in-order model
// of rr and divDone. Included by the
// FP issue testbench module.
////////////////////////////////////////
`ifndef FP_ISSUE_TESTS_SVH
`define FP_ISSUE_TESTS_SVH

typedef struct packed {
    FpOpTypes::OpId        opId;
    ActiveListTypes::AlPtr alPtr;
    FpOpTypes::FpOpKind    kind;
    logic                  replay;
} ExpOp;

typedef struct {
    int                    cycle;
    ActiveListTypes::AlPtr alPtr;
} DoneExp;

// Ops expected on rr, oldest first, lane 0 before lane 1
ExpOp   expQ [$];
DoneExp doneQ [$];
int     seenCycle [256];
int     seenLane [256];

function automatic FpOpTypes::FpOpKind pickArithKind();
    return FpOpTypes::FpOpKind'($urandom_range(2, 0));
endfunction

task automatic checkRrLane(input int lane);
    ExpOp exp;
    assert (expQ.size() > 0) else
        failCheck($sformatf("Op %h showed up on rr lane %0d with no op expected",
            rrOpId[lane], lane));
    exp = expQ.pop_front();
    assert (rrOpId[lane] == exp.opId) else failCheck($sformatf(
        "Error: rrOpId[%0d] is %h, expected %h", lane, rrOpId[lane], exp.opId));
    assert (rrAlPtr[lane] == exp.alPtr) else failCheck($sformatf(
        "Error: rrAlPtr[%0d] is %h, expected %h", lane, rrAlPtr[lane], exp.alPtr));
    assert (rrKind[lane] == exp.kind) else failCheck($sformatf(
        "Error: rrKind[%0d] is %h, expected %h", lane, rrKind[lane], exp.kind));
    assert (rrReplay[lane] == exp.replay) else failCheck($sformatf(
        "Error: rrReplay[%0d] is %h, expected %h", lane, rrReplay[lane], exp.replay));
    seenCycle[exp.opId] = cycleCount;
    seenLane[exp.opId] = lane;
    // A fresh div or sqrt locks the unit on the edge it reaches rr
    if ((exp.kind == FpOpTypes::DIV || exp.kind == FpOpTypes::SQRT) && !exp.replay) begin
        doneQ.push_back('{cycleCount + DivLatency, exp.alPtr});
    end
endtask

task automatic checkDivDone();
    if (doneQ.size() > 0) begin
        assert (doneQ[0].cycle >= cycleCount) else
            failCheck($sformatf("No divDone for pointer %h when it was due", doneQ[0].alPtr));
    end
    if (divDone) begin
        assert (doneQ.size() > 0 && doneQ[0].cycle == cycleCount) else
            failCheck($sformatf("Error: divDone is %h with no completion due", divDone));
        assert (divDoneAlPtr == doneQ[0].alPtr) else failCheck($sformatf(
            "Error: divDoneAlPtr is %h, expected %h", divDoneAlPtr, doneQ[0].alPtr));
        void'(doneQ.pop_front());
    end
endtask

task automatic dispatchOp(input FpOpTypes::FpOpKind kind, input ActiveListTypes::AlPtr alPtr,
        output ExpOp op);
    op = '{opCounter, alPtr, kind, 1'b0};
    dispValid <= 1'b1;
    dispKind <= kind;
    dispAlPtr <= alPtr;
    dispOpId <= opCounter;
    @(negedge clk);
    assert (dispReady) else
        failCheck($sformatf("Error: dispReady is %h during dispatch of %h", dispReady, opCounter));
    @(posedge clk);
    opCounter++;
endtask

task automatic waitDrain();
    int waited;
    waited = 0;
    while ((expQ.size() > 0 || doneQ.size() > 0) && waited < DrainLimit) begin
        @(posedge clk);
        waited++;
    end
    assert (expQ.size() == 0 && doneQ.size() == 0) else
        failCheck("Timed out waiting for the expected ops and completions");
endtask

// Parks a batch in the queue under stall, in dispatch order
task automatic parkBatch(input int count, input ActiveListTypes::AlPtr base,
        input logic arith, output ExpOp ops [8]);
    stall <= 1'b1;
    for (int i = 0; i < count; i++) begin
        dispatchOp(arith ? pickArithKind() : FpOpTypes::DIV,
            ActiveListTypes::AlPtr'(base + i), ops[i]);
        expQ.push_back(ops[i]);
    end
    dispValid <= 1'b0;
endtask

task automatic runBasicBatch();
    ExpOp ops [8];
    parkBatch(6, ActiveListTypes::AlPtr'($urandom), 1'b1, ops);
    stall <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    assert (rrValid == '0) else
        failCheck($sformatf("Error: rrValid is %h one cycle after selection, expected 0", rrValid));
    @(posedge clk);
    @(negedge clk);
    assert (rrValid == '1) else
        failCheck($sformatf("Error: rrValid is %h two cycles after selection, expected 3", rrValid));
    @(posedge clk);
    waitDrain();
endtask

task automatic fillQueue();
    ExpOp ops [8];
    int waited;
    parkBatch(QueueDepth, ActiveListTypes::AlPtr'($urandom), 1'b1, ops);
    @(negedge clk);
    assert (!dispReady) else
        failCheck($sformatf("Error: dispReady is %h with the queue full, expected 0", dispReady));
    @(posedge clk);
    stall <= 1'b0;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!dispReady && waited < 8);
    assert (dispReady) else failCheck("dispReady never rose after the queue drained");
    @(posedge clk);
    waitDrain();
endtask

task automatic runDivPair();
    ExpOp ops [8];
    parkBatch(2, ActiveListTypes::AlPtr'($urandom), 1'b0, ops);
    stall <= 1'b0;
    waitDrain();
    assert (seenLane[ops[0].opId] == 0) else
        failCheck($sformatf("Error: first DIV lane is %h, expected 0", seenLane[ops[0].opId]));
    assert (seenLane[ops[1].opId] == 0) else
        failCheck($sformatf("Error: second DIV lane is %h, expected 0", seenLane[ops[1].opId]));
    // Second DIV waits for the lock to fall, then takes the normal two cycles
    assert (seenCycle[ops[1].opId] == seenCycle[ops[0].opId] + DivLatency + 2) else
        failCheck($sformatf("Error: second DIV rr cycle is %h, expected %h",
            seenCycle[ops[1].opId], seenCycle[ops[0].opId] + DivLatency + 2));
endtask

task automatic flushDuringStall();
    ExpOp ops [8];
    ExpOp divOps [8];
    ActiveListTypes::AlPtr base;
    ActiveListTypes::AlPtr divPtr;
    base = ActiveListTypes::AlPtr'($urandom);
    parkBatch(4, base, 1'b1, ops);
    expQ.delete();
    stall <= 1'b0;
    @(posedge clk);
    // First pair sits in the stage, flushed while held
    stall <= 1'b1;
    recoveryActive <= 1'b1;
    flushHead <= base;
    flushTail <= ActiveListTypes::AlPtr'(base + 2);
    flushAll <= 1'b0;
    repeat (2) @(posedge clk);
    stall <= 1'b0;
    expQ.push_back(ops[2]);
    expQ.push_back(ops[3]);
    waitDrain();
    repeat (8) @(posedge clk);
    // Still in the queue, so they issue once recovery ends
    expQ.push_back(ops[0]);
    expQ.push_back(ops[1]);
    recoveryActive <= 1'b0;
    waitDrain();
    // A DIV that locked the unit is flushed and must never complete
    divPtr = ActiveListTypes::AlPtr'(base + 8);
    parkBatch(1, divPtr, 1'b0, divOps);
    stall <= 1'b0;
    repeat (3) @(posedge clk);
    assert (expQ.size() == 0) else failCheck("Flushed DIV never reached rr");
    doneQ.delete();
    recoveryActive <= 1'b1;
    flushHead <= divPtr;
    flushTail <= ActiveListTypes::AlPtr'(divPtr + 1);
    @(posedge clk);
    recoveryActive <= 1'b0;
    repeat (DivLatency + 2) @(posedge clk);
endtask

task automatic clearAndReplay();
    ExpOp ops [8];
    parkBatch(2, ActiveListTypes::AlPtr'($urandom), 1'b1, ops);
    stall <= 1'b0;
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    waitDrain();
    ops[0].replay = 1'b1;
    ops[1].replay = 1'b1;
    expQ.push_back(ops[0]);
    expQ.push_back(ops[1]);
    replayReq <= 1'b1;
    @(posedge clk);
    replayReq <= 1'b0;
    waitDrain();
endtask

task automatic holdStall();
    ExpOp ops [8];
    logic [IssueWidth-1:0] heldValid;
    FpOpTypes::OpId heldId [IssueWidth];
    parkBatch(4, ActiveListTypes::AlPtr'($urandom), 1'b1, ops);
    stall <= 1'b0;
    repeat (2) @(posedge clk);
    stall <= 1'b1;
    @(negedge clk);
    heldValid = rrValid;
    heldId = rrOpId;
    assert (heldValid == '1) else
        failCheck($sformatf("Error: rrValid is %h before the hold, expected 3", heldValid));
    repeat (6) begin
        @(posedge clk);
        @(negedge clk);
        assert (rrValid == heldValid) else failCheck($sformatf(
            "Error: rrValid is %h during stall, expected %h", rrValid, heldValid));
        for (int l = 0; l < IssueWidth; l++) begin
            assert (rrOpId[l] == heldId[l]) else failCheck($sformatf(
                "Error: rrOpId[%0d] is %h during stall, expected %h", l, rrOpId[l], heldId[l]));
        end
    end
    @(posedge clk);
    stall <= 1'b0;
    waitDrain();
endtask

`endif

/* testbench/FpIssueTb.sv */
////////////////////////////////////////
// Testbench for the FP issue subsystem.
// Clock, reset, DUT, rr and divDone
// monitor, watchdog and test sequence.
////////////////////////////////////////
`timescale 1ns/1ns

module FpIssueTb;

    localparam int IssueWidth = 2;
    localparam int DivSqrtIssueWidth = 1;
    localparam int QueueDepth = 8;
    localparam int DivLatency = 6;
    localparam int ClkPeriod = 40;
    localparam int ResetCycles = 8;
    localparam int DrainLimit = 2 * QueueDepth + 3 * DivLatency + 16;
    // Six tests, each a few drains plus setup cycles
    localparam int TimeoutCycles = ResetCycles + 6 * (2 * DrainLimit + QueueDepth + 20);

    logic                  clk = 1'b0;
    logic                  arstN;
    logic                  dispValid;
    FpOpTypes::FpOpKind    dispKind;
    ActiveListTypes::AlPtr dispAlPtr;
    FpOpTypes::OpId        dispOpId;
    logic                  dispReady;
    logic                  stall;
    logic                  clear;
    logic                  replayReq;
    logic                  recoveryActive;
    ActiveListTypes::AlPtr flushHead;
    ActiveListTypes::AlPtr flushTail;
    logic                  flushAll;
    logic [IssueWidth-1:0] rrValid;
    FpOpTypes::FpOpKind    rrKind [IssueWidth];
    ActiveListTypes::AlPtr rrAlPtr [IssueWidth];
    FpOpTypes::OpId        rrOpId [IssueWidth];
    logic [IssueWidth-1:0] rrReplay;
    logic                  divDone;
    ActiveListTypes::AlPtr divDoneAlPtr;

    int             errorCount = 0;
    int             cycleCount = 0;
    FpOpTypes::OpId opCounter = 8'h10;
    // Stall seen in the cycle before the last edge
    logic           stallSeen = 1'b1;

    task automatic failCheck(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    `include "FpIssueTests.svh"

    FpIssueSubsystem #(
        .IssueWidth(IssueWidth),
        .DivSqrtIssueWidth(DivSqrtIssueWidth),
        .QueueDepth(QueueDepth),
        .DivLatency(DivLatency)
    ) FpIssueSubsystem_inst (
        .clk(clk), .arstN(arstN),
        .dispValid(dispValid), .dispKind(dispKind), .dispAlPtr(dispAlPtr),
        .dispOpId(dispOpId), .dispReady(dispReady),
        .stall(stall), .clear(clear), .replayReq(replayReq),
        .recoveryActive(recoveryActive), .flushHead(flushHead),
        .flushTail(flushTail), .flushAll(flushAll),
        .rrValid(rrValid), .rrKind(rrKind), .rrAlPtr(rrAlPtr),
        .rrOpId(rrOpId), .rrReplay(rrReplay),
        .divDone(divDone), .divDoneAlPtr(divDoneAlPtr)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // rr only takes new ops on edges without stall
    always @(negedge clk) begin
        if (arstN) begin
            if (!stallSeen) begin
                for (int l = 0; l < IssueWidth; l++) begin
                    if (rrValid[l]) begin
                        checkRrLane(l);
                    end
                end
            end
            checkDivDone();
        end
        stallSeen = stall;
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles without the tests finishing", TimeoutCycles);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(8));
        arstN <= 1'b0;
        dispValid <= 1'b0;
        dispKind <= FpOpTypes::ADD;
        dispAlPtr <= '0;
        dispOpId <= '0;
        stall <= 1'b0;
        clear <= 1'b0;
        replayReq <= 1'b0;
        recoveryActive <= 1'b0;
        flushHead <= '0;
        flushTail <= '0;
        flushAll <= 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        assert (dispReady) else failCheck($sformatf("Error: dispReady is %h after reset", dispReady));
        assert (rrValid == '0) else failCheck($sformatf("Error: rrValid is %h after reset", rrValid));
        assert (!divDone) else failCheck($sformatf("Error: divDone is %h after reset", divDone));
        @(posedge clk);
        runBasicBatch();
        fillQueue();
        runDivPair();
        flushDuringStall();
        clearAndReplay();
        holdStall();
        // Room for any stray completion to show up
        repeat (2 * DivLatency) @(posedge clk);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* hdl/FpIssueSubsystem.sv */
////////////////////////////////////////
// FP issue subsystem top level. Sets the
// widths and connects queue, issue stage,
// divider and register-read latch.
////////////////////////////////////////
`timescale 1ns/1ns

module FpIssueSubsystem #(
    parameter int IssueWidth = 2,
    parameter int DivSqrtIssueWidth = 1,
    parameter int QueueDepth = 8,
    parameter int DivLatency = 6
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  dispValid,
    input  FpOpTypes::FpOpKind    dispKind,
    input  ActiveListTypes::AlPtr dispAlPtr,
    input  FpOpTypes::OpId        dispOpId,
    output logic                  dispReady,
    input  logic                  stall,
    input  logic                  clear,
    input  logic                  replayReq,
    input  logic                  recoveryActive,
    input  ActiveListTypes::AlPtr flushHead,
    input  ActiveListTypes::AlPtr flushTail,
    input  logic                  flushAll,
    output logic [IssueWidth-1:0] rrValid,
    output FpOpTypes::FpOpKind    rrKind [IssueWidth],
    output ActiveListTypes::AlPtr rrAlPtr [IssueWidth],
    output FpOpTypes::OpId        rrOpId [IssueWidth],
    output logic [IssueWidth-1:0] rrReplay,
    output logic                  divDone,
    output ActiveListTypes::AlPtr divDoneAlPtr
);

    localparam int QueuePtrWidth = $clog2(QueueDepth);

    logic [IssueWidth-1:0]    selValid;
    logic [QueuePtrWidth-1:0] selPtr [IssueWidth];
    logic [IssueWidth-1:0]    issue;
    logic [QueuePtrWidth-1:0] issuePtr [IssueWidth];
    FpOpTypes::FpOpKind       issuedKind [IssueWidth];
    ActiveListTypes::AlPtr    issuedAlPtr [IssueWidth];
    FpOpTypes::OpId           issuedOpId [IssueWidth];
    logic                     replay;
    logic [IssueWidth-1:0]    replayValid;
    FpOpTypes::FpOpKind       replayKind [IssueWidth];
    ActiveListTypes::AlPtr    replayAlPtr [IssueWidth];
    FpOpTypes::OpId           replayOpId [IssueWidth];
    logic                     stageHoldsDiv;
    logic                     acquire;
    ActiveListTypes::AlPtr    acquireAlPtr;
    logic                     divBusy;
    logic [IssueWidth-1:0]    nextValid;
    FpOpTypes::FpOpKind       nextKind [IssueWidth];
    ActiveListTypes::AlPtr    nextAlPtr [IssueWidth];
    FpOpTypes::OpId           nextOpId [IssueWidth];
    logic [IssueWidth-1:0]    nextReplay;

    FpIssueQueue #(
        .IssueWidth(IssueWidth),
        .DivSqrtIssueWidth(DivSqrtIssueWidth),
        .QueueDepth(QueueDepth)
    ) FpIssueQueue_inst (
        .clk(clk), .arstN(arstN),
        .dispValid(dispValid), .dispKind(dispKind), .dispAlPtr(dispAlPtr),
        .dispOpId(dispOpId), .dispReady(dispReady),
        .stall(stall), .divBusy(divBusy), .stageHoldsDiv(stageHoldsDiv),
        .replayReq(replayReq), .issue(issue), .issuePtr(issuePtr),
        .selValid(selValid), .selPtr(selPtr),
        .issuedKind(issuedKind), .issuedAlPtr(issuedAlPtr), .issuedOpId(issuedOpId),
        .replay(replay), .replayValid(replayValid), .replayKind(replayKind),
        .replayAlPtr(replayAlPtr), .replayOpId(replayOpId)
    );

    FpIssueStage #(
        .IssueWidth(IssueWidth),
        .DivSqrtIssueWidth(DivSqrtIssueWidth),
        .QueueDepth(QueueDepth)
    ) FpIssueStage_inst (
        .clk(clk), .arstN(arstN), .stall(stall), .clear(clear),
        .selValid(selValid), .selPtr(selPtr),
        .issuedKind(issuedKind), .issuedAlPtr(issuedAlPtr), .issuedOpId(issuedOpId),
        .replay(replay), .replayValid(replayValid), .replayKind(replayKind),
        .replayAlPtr(replayAlPtr), .replayOpId(replayOpId),
        .recoveryActive(recoveryActive), .flushHead(flushHead),
        .flushTail(flushTail), .flushAll(flushAll),
        .issue(issue), .issuePtr(issuePtr), .stageHoldsDiv(stageHoldsDiv),
        .acquire(acquire), .acquireAlPtr(acquireAlPtr),
        .nextValid(nextValid), .nextKind(nextKind), .nextAlPtr(nextAlPtr),
        .nextOpId(nextOpId), .nextReplay(nextReplay)
    );

    FpDivSqrtUnit #(
        .DivLatency(DivLatency)
    ) FpDivSqrtUnit_inst (
        .clk(clk), .arstN(arstN),
        .acquire(acquire), .acquireAlPtr(acquireAlPtr),
        .recoveryActive(recoveryActive), .flushHead(flushHead),
        .flushTail(flushTail), .flushAll(flushAll),
        .divBusy(divBusy), .divDone(divDone), .divDoneAlPtr(divDoneAlPtr)
    );

    FpRegisterReadStage #(
        .IssueWidth(IssueWidth)
    ) FpRegisterReadStage_inst (
        .clk(clk), .arstN(arstN), .stall(stall), .clear(clear),
        .recoveryActive(recoveryActive), .flushHead(flushHead),
        .flushTail(flushTail), .flushAll(flushAll),
        .nextValid(nextValid), .nextKind(nextKind), .nextAlPtr(nextAlPtr),
        .nextOpId(nextOpId), .nextReplay(nextReplay),
        .rrValid(rrValid), .rrKind(rrKind), .rrAlPtr(rrAlPtr),
        .rrOpId(rrOpId), .rrReplay(rrReplay)
    );

endmodule

/* hdl/FpRegisterReadStage.sv */
////////////////////////////////////////
// Register-read latch after FP issue.
// Holds on stall, drops flushed ops.
////////////////////////////////////////
`timescale 1ns/1ns

module FpRegisterReadStage #(
    parameter int IssueWidth = 2
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  stall,
    input  logic                  clear,
    input  logic                  recoveryActive,
    input  ActiveListTypes::AlPtr flushHead,
    input  ActiveListTypes::AlPtr flushTail,
    input  logic                  flushAll,
    input  logic [IssueWidth-1:0] nextValid,
    input  FpOpTypes::FpOpKind    nextKind [IssueWidth],
    input  ActiveListTypes::AlPtr nextAlPtr [IssueWidth],
    input  FpOpTypes::OpId        nextOpId [IssueWidth],
    input  logic [IssueWidth-1:0] nextReplay,
    output logic [IssueWidth-1:0] rrValid,
    output FpOpTypes::FpOpKind    rrKind [IssueWidth],
    output ActiveListTypes::AlPtr rrAlPtr [IssueWidth],
    output FpOpTypes::OpId        rrOpId [IssueWidth],
    output logic [IssueWidth-1:0] rrReplay
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rrValid <= '0;
        end else if (clear) begin
            rrValid <= '0;
        end else if (!stall) begin
            rrValid <= nextValid;
        end else begin
            for (int i = 0; i < IssueWidth; i++) begin
                rrValid[i] <= rrValid[i] && !ActiveListTypes::inFlushRange(
                    recoveryActive, flushHead, flushTail, flushAll, rrAlPtr[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rrKind <= nextKind;
            rrAlPtr <= nextAlPtr;
            rrOpId <= nextOpId;
            rrReplay <= nextReplay;
        end
    end

endmodule

/* hdl/FpDivSqrtUnit.sv */
////////////////////////////////////////
// Iterative div/sqrt model. Locked by an
// acquire, reports done after DivLatency.
////////////////////////////////////////
`timescale 1ns/1ns

module FpDivSqrtUnit #(
    parameter int DivLatency = 6,
    localparam int CountWidth = $clog2(DivLatency + 1)
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  acquire,
    input  ActiveListTypes::AlPtr acquireAlPtr,
    input  logic                  recoveryActive,
    input  ActiveListTypes::AlPtr flushHead,
    input  ActiveListTypes::AlPtr flushTail,
    input  logic                  flushAll,
    output logic                  divBusy,
    output logic                  divDone,
    output ActiveListTypes::AlPtr divDoneAlPtr
);

    logic [CountWidth-1:0] remaining;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            divBusy <= 1'b0;
            divDone <= 1'b0;
            remaining <= '0;
        end else begin
            divDone <= 1'b0;
            if (acquire) begin
                divBusy <= 1'b1;
                remaining <= CountWidth'(DivLatency - 1);
            end else if (divBusy) begin
                if (ActiveListTypes::inFlushRange(
                        recoveryActive, flushHead, flushTail, flushAll, divDoneAlPtr)) begin
                    // Cancelled, no completion
                    divBusy <= 1'b0;
                end else if (remaining == '0) begin
                    divBusy <= 1'b0;
                    divDone <= 1'b1;
                end else begin
                    remaining <= remaining - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire) begin
            divDoneAlPtr <= acquireAlPtr;
        end
    end

    // Select logic must never hand a div to a locked unit
    assert property (@(posedge clk) disable iff (!arstN) acquire |-> !divBusy);

endmodule

/* hdl/FpIssueStage.sv */
////////////////////////////////////////
// FP issue stage. Registers the selected
// queue pointers, filters flushed ops and
// confirms issue and div/sqrt acquire.
////////////////////////////////////////
`timescale 1ns/1ns

module FpIssueStage #(
    parameter int IssueWidth = 2,
    parameter int DivSqrtIssueWidth = 1,
    parameter int QueueDepth = 8,
    localparam int QueuePtrWidth = $clog2(QueueDepth)
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     stall,
    input  logic                     clear,
    input  logic [IssueWidth-1:0]    selValid,
    input  logic [QueuePtrWidth-1:0] selPtr [IssueWidth],
    input  FpOpTypes::FpOpKind       issuedKind [IssueWidth],
    input  ActiveListTypes::AlPtr    issuedAlPtr [IssueWidth],
    input  FpOpTypes::OpId           issuedOpId [IssueWidth],
    input  logic                     replay,
    input  logic [IssueWidth-1:0]    replayValid,
    input  FpOpTypes::FpOpKind       replayKind [IssueWidth],
    input  ActiveListTypes::AlPtr    replayAlPtr [IssueWidth],
    input  FpOpTypes::OpId           replayOpId [IssueWidth],
    input  logic                     recoveryActive,
    input  ActiveListTypes::AlPtr    flushHead,
    input  ActiveListTypes::AlPtr    flushTail,
    input  logic                     flushAll,
    output logic [IssueWidth-1:0]    issue,
    output logic [QueuePtrWidth-1:0] issuePtr [IssueWidth],
    output logic                     stageHoldsDiv,
    output logic                     acquire,
    output ActiveListTypes::AlPtr    acquireAlPtr,
    output logic [IssueWidth-1:0]    nextValid,
    output FpOpTypes::FpOpKind       nextKind [IssueWidth],
    output ActiveListTypes::AlPtr    nextAlPtr [IssueWidth],
    output FpOpTypes::OpId           nextOpId [IssueWidth],
    output logic [IssueWidth-1:0]    nextReplay
);

    logic [IssueWidth-1:0]    pipeValid;
    logic [QueuePtrWidth-1:0] pipePtr [IssueWidth];
    logic [IssueWidth-1:0]    laneValid;
    logic [IssueWidth-1:0]    laneFlush;
    logic [IssueWidth-1:0]    laneAcquire;
    FpOpTypes::FpOpKind       laneKind [IssueWidth];
    ActiveListTypes::AlPtr    laneAlPtr [IssueWidth];
    FpOpTypes::OpId           laneOpId [IssueWidth];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pipeValid <= '0;
        end else if (!stall) begin
            pipeValid <= selValid;
        end else begin
            // Held ops caught by a recovery are dropped
            for (int i = 0; i < IssueWidth; i++) begin
                pipeValid[i] <= pipeValid[i] && !ActiveListTypes::inFlushRange(
                    recoveryActive, flushHead, flushTail, flushAll, issuedAlPtr[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipePtr <= selPtr;
        end
    end

    always_comb begin
        stageHoldsDiv = 1'b0;
        for (int i = 0; i < IssueWidth; i++) begin
            if (replay) begin
                laneKind[i] = replayKind[i];
                laneAlPtr[i] = replayAlPtr[i];
                laneOpId[i] = replayOpId[i];
                laneValid[i] = replayValid[i] && !stall;
            end else begin
                laneKind[i] = issuedKind[i];
                laneAlPtr[i] = issuedAlPtr[i];
                laneOpId[i] = issuedOpId[i];
                laneValid[i] = pipeValid[i] && !stall;
            end
            laneFlush[i] = ActiveListTypes::inFlushRange(
                recoveryActive, flushHead, flushTail, flushAll, laneAlPtr[i]);
            nextValid[i] = !clear && laneValid[i] && !laneFlush[i];
            nextKind[i] = laneKind[i];
            nextAlPtr[i] = laneAlPtr[i];
            nextOpId[i] = laneOpId[i];
            nextReplay[i] = replay;
            // A replayed group is already out of the queue
            issue[i] = nextValid[i] && !replay;
            issuePtr[i] = pipePtr[i];
            laneAcquire[i] = issue[i] && FpOpTypes::isDivSqrt(laneKind[i]);
            stageHoldsDiv = stageHoldsDiv ||
                (pipeValid[i] && FpOpTypes::isDivSqrt(issuedKind[i]));
        end
    end

    // Lock the divider from the div-capable lanes
    always_comb begin
        acquire = 1'b0;
        acquireAlPtr = laneAlPtr[0];
        for (int i = 0; i < DivSqrtIssueWidth; i++) begin
            if (laneAcquire[i]) begin
                acquire = 1'b1;
                acquireAlPtr = laneAlPtr[i];
            end
        end
    end

    for (genvar i = DivSqrtIssueWidth; i < IssueWidth; i++) begin : gLaneCheck
        // Queue keeps div and sqrt off the upper lanes
        assert property (@(posedge clk) disable iff (!arstN) !laneAcquire[i]);
    end

endmodule

/* hdl/FpIssueQueue.sv */
////////////////////////////////////////
// FP issue queue. Holds dispatched ops,
// selects up to IssueWidth per cycle and
// frees entries on the issue strobe.
////////////////////////////////////////
`timescale 1ns/1ns

module FpIssueQueue #(
    parameter int IssueWidth = 2,
    parameter int DivSqrtIssueWidth = 1,
    parameter int QueueDepth = 8,
    localparam int QueuePtrWidth = $clog2(QueueDepth)
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     dispValid,
    input  FpOpTypes::FpOpKind       dispKind,
    input  ActiveListTypes::AlPtr    dispAlPtr,
    input  FpOpTypes::OpId           dispOpId,
    output logic                     dispReady,
    input  logic                     stall,
    input  logic                     divBusy,
    input  logic                     stageHoldsDiv,
    input  logic                     replayReq,
    input  logic [IssueWidth-1:0]    issue,
    input  logic [QueuePtrWidth-1:0] issuePtr [IssueWidth],
    output logic [IssueWidth-1:0]    selValid,
    output logic [QueuePtrWidth-1:0] selPtr [IssueWidth],
    output FpOpTypes::FpOpKind       issuedKind [IssueWidth],
    output ActiveListTypes::AlPtr    issuedAlPtr [IssueWidth],
    output FpOpTypes::OpId           issuedOpId [IssueWidth],
    output logic                     replay,
    output logic [IssueWidth-1:0]    replayValid,
    output FpOpTypes::FpOpKind       replayKind [IssueWidth],
    output ActiveListTypes::AlPtr    replayAlPtr [IssueWidth],
    output FpOpTypes::OpId           replayOpId [IssueWidth]
);

    logic [QueueDepth-1:0]    entryValid;
    logic [QueueDepth-1:0]    inFlight;
    FpOpTypes::FpOpKind       entryKind [QueueDepth];
    ActiveListTypes::AlPtr    entryAlPtr [QueueDepth];
    FpOpTypes::OpId           entryOpId [QueueDepth];
    logic [IssueWidth-1:0]    heldValid;
    logic [QueuePtrWidth-1:0] freePtr;

    // Lowest free slot takes the next dispatch
    always_comb begin
        dispReady = 1'b0;
        freePtr = '0;
        for (int e = QueueDepth - 1; e >= 0; e--) begin
            if (!entryValid[e]) begin
                dispReady = 1'b1;
                freePtr = QueuePtrWidth'(e);
            end
        end
    end

    // Lane by lane, lowest index first, at most one div/sqrt per cycle
    always_comb begin
        logic [QueueDepth-1:0] taken;
        logic divTaken;
        logic divOp;
        taken = '0;
        divTaken = divBusy || stageHoldsDiv;
        for (int l = 0; l < IssueWidth; l++) begin
            selValid[l] = 1'b0;
            selPtr[l] = '0;
            for (int e = 0; e < QueueDepth; e++) begin
                divOp = FpOpTypes::isDivSqrt(entryKind[e]);
                if (!selValid[l] && !stall && entryValid[e] && !inFlight[e] && !taken[e] &&
                    (!divOp || (l < DivSqrtIssueWidth && !divTaken))) begin
                    selValid[l] = 1'b1;
                    selPtr[l] = QueuePtrWidth'(e);
                    taken[e] = 1'b1;
                    divTaken = divTaken || divOp;
                end
            end
        end
    end

    // Entry currently held by the stage
    always_comb begin
        for (int l = 0; l < IssueWidth; l++) begin
            issuedKind[l] = entryKind[issuePtr[l]];
            issuedAlPtr[l] = entryAlPtr[issuePtr[l]];
            issuedOpId[l] = entryOpId[issuePtr[l]];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
            inFlight <= '0;
            heldValid <= '0;
            replay <= 1'b0;
            replayValid <= '0;
        end else begin
            replay <= replayReq;
            if (!stall) begin
                heldValid <= selValid;
                for (int l = 0; l < IssueWidth; l++) begin
                    // Held but not confirmed, so it may be picked again
                    if (heldValid[l] && !issue[l]) begin
                        inFlight[issuePtr[l]] <= 1'b0;
                    end
                    if (selValid[l]) begin
                        inFlight[selPtr[l]] <= 1'b1;
                    end
                end
            end
            for (int l = 0; l < IssueWidth; l++) begin
                if (issue[l]) begin
                    entryValid[issuePtr[l]] <= 1'b0;
                    inFlight[issuePtr[l]] <= 1'b0;
                end
            end
            if (|issue) begin
                replayValid <= issue;
            end
            if (dispValid && dispReady) begin
                entryValid[freePtr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispValid && dispReady) begin
            entryKind[freePtr] <= dispKind;
            entryAlPtr[freePtr] <= dispAlPtr;
            entryOpId[freePtr] <= dispOpId;
        end
        // Copy of the last issued group
        for (int l = 0; l < IssueWidth; l++) begin
            if (issue[l]) begin
                replayKind[l] <= issuedKind[l];
                replayAlPtr[l] <= issuedAlPtr[l];
                replayOpId[l] <= issuedOpId[l];
            end
        end
    end

    for (genvar l = 0; l < IssueWidth; l++) begin : gIssueCheck
        // Stage confirms only entries that are still allocated
        assert property (@(posedge clk) disable iff (!arstN)
            issue[l] |-> entryValid[issuePtr[l]]);
    end

endmodule

/* hdl/ActiveListTypes.sv */
////////////////////////////////////////
// Active-list pointer type and the test
// used by every stage during recovery.
////////////////////////////////////////
package ActiveListTypes;

    localparam int AlPtrWidth = 5;

    typedef logic [AlPtrWidth-1:0] AlPtr;

    // Head inclusive, tail exclusive, wrapping around the list
    function automatic logic inFlushRange(
        input logic recoveryActive,
        input AlPtr head,
        input AlPtr tail,
        input logic flushAll,
        input AlPtr ptr
    );
        logic inRange;
        if (head < tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end else if (head > tail) begin
            inRange = (ptr >= head) || (ptr < tail);
        end else begin
            // Empty range
            inRange = 1'b0;
        end
        return recoveryActive && (flushAll || inRange);
    endfunction

endpackage

/* hdl/FpOpTypes.sv */
////////////////////////////////////////
// Floating-point micro-op kinds and the
// fields kept in each issue queue entry.
// Used through scoped names only.
////////////////////////////////////////
package FpOpTypes;

    localparam int OpIdWidth = 8;

    typedef enum logic [2:0] {
        ADD  = 3'd0,
        MUL  = 3'd1,
        FMA  = 3'd2,
        DIV  = 3'd3,
        SQRT = 3'd4
    } FpOpKind;

    // Tag that follows an op down the pipe
    typedef logic [OpIdWidth-1:0] OpId;

    // Ops that need the iterative unit
    function automatic logic isDivSqrt(input FpOpKind kind);
        return (kind == DIV) || (kind == SQRT);
    endfunction

endpackage
